// ==== build.f ====
+incdir+common
common/dbus_pkg.sv
src/dbus_master_mux.sv
src/dbus_slave_decode.sv
src/dbus_watchdog.sv
src/dbus_slave_router.sv
src/arbiter_dbus.sv
tb/tb_arbiter_dbus.sv

// ==== common/dbus_config.svh ====
`ifndef DBUS_CONFIG_SVH
`define DBUS_CONFIG_SVH

// Bus widths
`define DBUS_ADR_WIDTH 32
`define DBUS_DAT_WIDTH 32
`define DBUS_SEL_WIDTH 4
`define DBUS_NUM_SLAVES 4

// Address decode regions and the Ethernet match on the top address byte
`define DBUS_MATCH_WIDTH 8
`define DBUS_ETH_MATCH 8'h92
`define DBUS_DDR_ADR_WIDTH 28
`define DBUS_RAM_ADR_WIDTH 24

// Stall timer runs one bit wider than this
`define DBUS_WD_WIDTH 6

`endif

// ==== common/dbus_pkg.sv ====
`include "dbus_config.svh"

package dbus_pkg;

   typedef logic [`DBUS_ADR_WIDTH-1:0] adr_t;
   typedef logic [`DBUS_DAT_WIDTH-1:0] dat_t;
   typedef logic [`DBUS_SEL_WIDTH-1:0] sel_t;

   // 0 DDR, 1 Ethernet, 2 byte bus, 3 ROM/RAM
   typedef logic [`DBUS_NUM_SLAVES-1:0] slave_vec_t;

   typedef logic [`DBUS_WD_WIDTH:0] wd_count_t;

endpackage

// ==== src/arbiter_dbus.sv ====
`timescale 1ns/100ps

module arbiter_dbus
   import dbus_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   // CPU data master
   input  adr_t       wbm0_adr_i,
   input  dat_t       wbm0_dat_i,
   input  sel_t       wbm0_sel_i,
   input  logic       wbm0_we_i,
   input  logic       wbm0_cyc_i,
   input  logic       wbm0_stb_i,
   output dat_t       wbm0_dat_o,
   output logic       wbm0_ack_o,
   output logic       wbm0_err_o,
   output logic       wbm0_rty_o,
   // Debug master
   input  adr_t       wbm1_adr_i,
   input  dat_t       wbm1_dat_i,
   input  sel_t       wbm1_sel_i,
   input  logic       wbm1_we_i,
   input  logic       wbm1_cyc_i,
   input  logic       wbm1_stb_i,
   output dat_t       wbm1_dat_o,
   output logic       wbm1_ack_o,
   output logic       wbm1_err_o,
   output logic       wbm1_rty_o,
   // Shared slave request
   output adr_t       wbs_adr_o,
   output dat_t       wbs_dat_o,
   output sel_t       wbs_sel_o,
   output logic       wbs_we_o,
   output slave_vec_t wbs_cyc_o,
   output slave_vec_t wbs_stb_o,
   // Slave responses
   input  dat_t       wbs0_dat_i,
   input  dat_t       wbs1_dat_i,
   input  dat_t       wbs2_dat_i,
   input  dat_t       wbs3_dat_i,
   input  slave_vec_t wbs_ack_i,
   input  slave_vec_t wbs_err_i,
   input  slave_vec_t wbs_rty_i
);

   adr_t       bus_adr;
   dat_t       bus_dat;
   sel_t       bus_sel;
   logic       bus_we;
   logic       bus_cyc;
   logic       bus_stb;
   dat_t       bus_rdat;
   logic       bus_ack;
   logic       bus_err;
   logic       bus_rty;
   logic       slv_ack;
   slave_vec_t slave_sel;
   logic       wd_err;

   assign wbs_adr_o = bus_adr;
   assign wbs_dat_o = bus_dat;
   assign wbs_sel_o = bus_sel;
   assign wbs_we_o  = bus_we;

   dbus_master_mux dbus_master_mux_inst (
      .wbm0_adr_i (wbm0_adr_i), .wbm0_dat_i (wbm0_dat_i), .wbm0_sel_i (wbm0_sel_i),
      .wbm0_we_i  (wbm0_we_i),  .wbm0_cyc_i (wbm0_cyc_i), .wbm0_stb_i (wbm0_stb_i),
      .wbm1_adr_i (wbm1_adr_i), .wbm1_dat_i (wbm1_dat_i), .wbm1_sel_i (wbm1_sel_i),
      .wbm1_we_i  (wbm1_we_i),  .wbm1_cyc_i (wbm1_cyc_i), .wbm1_stb_i (wbm1_stb_i),
      .bus_adr_o  (bus_adr),    .bus_dat_o  (bus_dat),    .bus_sel_o  (bus_sel),
      .bus_we_o   (bus_we),     .bus_cyc_o  (bus_cyc),    .bus_stb_o  (bus_stb),
      .bus_rdat_i (bus_rdat),   .bus_ack_i  (bus_ack),
      .bus_err_i  (bus_err),    .bus_rty_i  (bus_rty),
      .wbm0_dat_o (wbm0_dat_o), .wbm0_ack_o (wbm0_ack_o),
      .wbm0_err_o (wbm0_err_o), .wbm0_rty_o (wbm0_rty_o),
      .wbm1_dat_o (wbm1_dat_o), .wbm1_ack_o (wbm1_ack_o),
      .wbm1_err_o (wbm1_err_o), .wbm1_rty_o (wbm1_rty_o)
   );

   dbus_slave_decode dbus_slave_decode_inst (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .bus_adr_i   (bus_adr),
      .slave_sel_o (slave_sel)
   );

   dbus_watchdog dbus_watchdog_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .bus_stb_i (bus_stb),
      .slv_ack_i (slv_ack),
      .wd_err_o  (wd_err)
   );

   dbus_slave_router dbus_slave_router_inst (
      .slave_sel_i (slave_sel),  .bus_cyc_i  (bus_cyc),
      .bus_stb_i   (bus_stb),    .wd_err_i   (wd_err),
      .wbs_cyc_o   (wbs_cyc_o),  .wbs_stb_o  (wbs_stb_o),
      .wbs0_dat_i  (wbs0_dat_i), .wbs1_dat_i (wbs1_dat_i),
      .wbs2_dat_i  (wbs2_dat_i), .wbs3_dat_i (wbs3_dat_i),
      .wbs_ack_i   (wbs_ack_i),  .wbs_err_i  (wbs_err_i),
      .wbs_rty_i   (wbs_rty_i),  .bus_rdat_o (bus_rdat),
      .bus_ack_o   (bus_ack),    .bus_err_o  (bus_err),
      .bus_rty_o   (bus_rty),    .slv_ack_o  (slv_ack)
   );

endmodule

// ==== src/dbus_master_mux.sv ====
`timescale 1ns/100ps

module dbus_master_mux
   import dbus_pkg::*;
(
   input  adr_t wbm0_adr_i,
   input  dat_t wbm0_dat_i,
   input  sel_t wbm0_sel_i,
   input  logic wbm0_we_i,
   input  logic wbm0_cyc_i,
   input  logic wbm0_stb_i,
   input  adr_t wbm1_adr_i,
   input  dat_t wbm1_dat_i,
   input  sel_t wbm1_sel_i,
   input  logic wbm1_we_i,
   input  logic wbm1_cyc_i,
   input  logic wbm1_stb_i,
   output adr_t bus_adr_o,
   output dat_t bus_dat_o,
   output sel_t bus_sel_o,
   output logic bus_we_o,
   output logic bus_cyc_o,
   output logic bus_stb_o,
   input  dat_t bus_rdat_i,
   input  logic bus_ack_i,
   input  logic bus_err_i,
   input  logic bus_rty_i,
   output dat_t wbm0_dat_o,
   output logic wbm0_ack_o,
   output logic wbm0_err_o,
   output logic wbm0_rty_o,
   output dat_t wbm1_dat_o,
   output logic wbm1_ack_o,
   output logic wbm1_err_o,
   output logic wbm1_rty_o
);

   logic cpu_sel;
   logic dbg_sel;

   // Debug master wins whenever it holds cyc
   assign dbg_sel = wbm1_cyc_i;
   assign cpu_sel = wbm0_cyc_i & ~wbm1_cyc_i;

   assign bus_adr_o = dbg_sel ? wbm1_adr_i : wbm0_adr_i;
   assign bus_dat_o = dbg_sel ? wbm1_dat_i : wbm0_dat_i;
   assign bus_sel_o = dbg_sel ? wbm1_sel_i : wbm0_sel_i;
   assign bus_we_o  = dbg_sel ? wbm1_we_i  : wbm0_we_i;
   assign bus_cyc_o = dbg_sel ? wbm1_cyc_i : wbm0_cyc_i;
   assign bus_stb_o = dbg_sel ? wbm1_stb_i : wbm0_stb_i;

   // Read data fans out to both masters and handshakes to the owner only
   assign wbm0_dat_o = bus_rdat_i;
   assign wbm1_dat_o = bus_rdat_i;
   assign wbm0_ack_o = bus_ack_i & cpu_sel;
   assign wbm0_err_o = bus_err_i & cpu_sel;
   assign wbm0_rty_o = bus_rty_i & cpu_sel;
   assign wbm1_ack_o = bus_ack_i & dbg_sel;
   assign wbm1_err_o = bus_err_i & dbg_sel;
   assign wbm1_rty_o = bus_rty_i & dbg_sel;

endmodule

// ==== src/dbus_slave_decode.sv ====
`timescale 1ns/100ps

`include "dbus_config.svh"

module dbus_slave_decode
   import dbus_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  adr_t       bus_adr_i,
   output slave_vec_t slave_sel_o
);

   logic       ram_hit;
   logic       ddr_hit;
   logic       eth_hit;
   slave_vec_t next_sel;

   assign ram_hit = ~|bus_adr_i[`DBUS_ADR_WIDTH-1:`DBUS_RAM_ADR_WIDTH];
   assign ddr_hit = ~|bus_adr_i[`DBUS_ADR_WIDTH-1:`DBUS_DDR_ADR_WIDTH];
   assign eth_hit = bus_adr_i[`DBUS_ADR_WIDTH-1 -: `DBUS_MATCH_WIDTH] == `DBUS_ETH_MATCH;

   // ROM/RAM sits inside the DDR window, so it is checked first
   always_comb begin
      if (ram_hit)
         next_sel = 4'b1000;
      else if (ddr_hit)
         next_sel = 4'b0001;
      else if (eth_hit)
         next_sel = 4'b0010;
      else
         next_sel = 4'b0100;
   end

   // Byte bus is the default slave
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         slave_sel_o <= 4'b0100;
      else
         slave_sel_o <= next_sel;
   end

endmodule

// ==== src/dbus_slave_router.sv ====
`timescale 1ns/100ps

`include "dbus_config.svh"

module dbus_slave_router
   import dbus_pkg::*;
(
   input  slave_vec_t slave_sel_i,
   input  logic       bus_cyc_i,
   input  logic       bus_stb_i,
   input  logic       wd_err_i,
   output slave_vec_t wbs_cyc_o,
   output slave_vec_t wbs_stb_o,
   input  dat_t       wbs0_dat_i,
   input  dat_t       wbs1_dat_i,
   input  dat_t       wbs2_dat_i,
   input  dat_t       wbs3_dat_i,
   input  slave_vec_t wbs_ack_i,
   input  slave_vec_t wbs_err_i,
   input  slave_vec_t wbs_rty_i,
   output dat_t       bus_rdat_o,
   output logic       bus_ack_o,
   output logic       bus_err_o,
   output logic       bus_rty_o,
   output logic       slv_ack_o
);

   // Only the decoded slave sees the cycle
   assign wbs_cyc_o = {`DBUS_NUM_SLAVES{bus_cyc_i}} & slave_sel_i;
   assign wbs_stb_o = {`DBUS_NUM_SLAVES{bus_stb_i}} & slave_sel_i;

   always_comb begin
      case (slave_sel_i)
         4'b0001: bus_rdat_o = wbs0_dat_i;
         4'b0010: bus_rdat_o = wbs1_dat_i;
         4'b1000: bus_rdat_o = wbs3_dat_i;
         default: bus_rdat_o = wbs2_dat_i;
      endcase
   end

   assign slv_ack_o = |(wbs_ack_i & slave_sel_i);

   // A watchdog timeout takes precedence over a late ack
   assign bus_ack_o = slv_ack_o & ~wd_err_i;
   assign bus_err_o = |(wbs_err_i & slave_sel_i) | wd_err_i;
   assign bus_rty_o = |(wbs_rty_i & slave_sel_i);

   ack_err_excl: assert final (!(bus_ack_o && bus_err_o))
      else $error("ack and err returned together");

endmodule

// ==== src/dbus_watchdog.sv ====
`timescale 1ns/100ps

`include "dbus_config.svh"

module dbus_watchdog
   import dbus_pkg::*;
(
   input  logic wb_clk,
   input  logic wb_rst,
   input  logic bus_stb_i,
   input  logic slv_ack_i,
   output logic wd_err_o
);

   logic      stb_r;
   logic      stb_edge;
   wd_count_t wd_count;

   assign stb_edge = bus_stb_i & ~stb_r;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         stb_r    <= 1'b0;
         wd_count <= '0;
         wd_err_o <= 1'b0;
      end else begin
         stb_r    <= bus_stb_i;
         // Fires once as the count wraps to zero
         wd_err_o <= &wd_count;
         if (slv_ack_i)
            wd_count <= '0;
         else if (stb_edge)
            wd_count <= wd_count_t'(1);
         else if (|wd_count)
            wd_count <= wd_count + 1'b1;
      end
   end

   // Strobe held without ack until the count is all ones
   stall_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
      ($rose(bus_stb_i) && !slv_ack_i) ##1
      (bus_stb_i && !slv_ack_i) [*(2**(`DBUS_WD_WIDTH+1) - 2)]
      |-> ##2 wd_err_o)
      else $error("stalled strobe raised no watchdog error");

endmodule

// ==== tb/tb_arbiter_dbus.sv ====
`timescale 1ns/100ps

module tb_arbiter_dbus
   import dbus_pkg::*;
();

   localparam int MODE_NONE = 0;
   localparam int MODE_ACK  = 1;
   localparam int MODE_ERR  = 2;
   localparam int MODE_RTY  = 3;

   localparam dat_t SLV0_DAT = 32'hDD00_1000;
   localparam dat_t SLV1_DAT = 32'hE700_2001;
   localparam dat_t SLV2_DAT = 32'hB500_3002;
   localparam dat_t SLV3_DAT = 32'hA300_4003;

   logic       wb_clk;
   logic       wb_rst;
   adr_t       m_adr [2];
   dat_t       m_dat [2];
   sel_t       m_sel [2];
   logic [1:0] m_we;
   logic [1:0] m_cyc;
   logic [1:0] m_stb;
   wire  [1:0] m_ack;
   wire  [1:0] m_err;
   wire  [1:0] m_rty;
   dat_t       wbm0_dat;
   dat_t       wbm1_dat;
   adr_t       wbs_adr_o;
   dat_t       wbs_dat_o;
   sel_t       wbs_sel_o;
   logic       wbs_we_o;
   slave_vec_t wbs_cyc_o;
   slave_vec_t wbs_stb_o;

   // Slave model state
   slave_vec_t slv_ack = '0;
   slave_vec_t slv_err = '0;
   slave_vec_t slv_rty = '0;
   int         slv_mode [4];
   int         slv_wait [4];
   int         stb_cnt [4];

   logic [31:0] lcg_state = 32'd6;
   int          err_count = 0;
   int          timeout_count = 0;

   arbiter_dbus arbiter_dbus_inst (
      .wb_clk     (wb_clk),    .wb_rst     (wb_rst),
      .wbm0_adr_i (m_adr[0]),  .wbm0_dat_i (m_dat[0]),  .wbm0_sel_i (m_sel[0]),
      .wbm0_we_i  (m_we[0]),   .wbm0_cyc_i (m_cyc[0]),  .wbm0_stb_i (m_stb[0]),
      .wbm0_dat_o (wbm0_dat),  .wbm0_ack_o (m_ack[0]),
      .wbm0_err_o (m_err[0]),  .wbm0_rty_o (m_rty[0]),
      .wbm1_adr_i (m_adr[1]),  .wbm1_dat_i (m_dat[1]),  .wbm1_sel_i (m_sel[1]),
      .wbm1_we_i  (m_we[1]),   .wbm1_cyc_i (m_cyc[1]),  .wbm1_stb_i (m_stb[1]),
      .wbm1_dat_o (wbm1_dat),  .wbm1_ack_o (m_ack[1]),
      .wbm1_err_o (m_err[1]),  .wbm1_rty_o (m_rty[1]),
      .wbs_adr_o  (wbs_adr_o), .wbs_dat_o  (wbs_dat_o), .wbs_sel_o  (wbs_sel_o),
      .wbs_we_o   (wbs_we_o),  .wbs_cyc_o  (wbs_cyc_o), .wbs_stb_o  (wbs_stb_o),
      .wbs0_dat_i (SLV0_DAT),  .wbs1_dat_i (SLV1_DAT),
      .wbs2_dat_i (SLV2_DAT),  .wbs3_dat_i (SLV3_DAT),
      .wbs_ack_i  (slv_ack),   .wbs_err_i  (slv_err),   .wbs_rty_i  (slv_rty)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   // Answers a strobe held for two edges, after slv_wait more cycles
   always @(posedge wb_clk) begin
      for (int s = 0; s < 4; s++) begin
         if (wb_rst || !wbs_stb_o[s] || slv_ack[s] || slv_err[s] || slv_rty[s]) begin
            stb_cnt[s] <= 0;
            slv_ack[s] <= 1'b0;
            slv_err[s] <= 1'b0;
            slv_rty[s] <= 1'b0;
         end else if (stb_cnt[s] >= 1 + slv_wait[s]) begin
            stb_cnt[s] <= 0;
            slv_ack[s] <= (slv_mode[s] == MODE_ACK);
            slv_err[s] <= (slv_mode[s] == MODE_ERR);
            slv_rty[s] <= (slv_mode[s] == MODE_RTY);
         end else begin
            stb_cnt[s] <= stb_cnt[s] + 1;
         end
      end
   end

   function automatic adr_t lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // ROM/RAM, then DDR, then Ethernet, else byte bus
   function automatic int expected_slave(input adr_t adr);
      if (adr[31:24] == 8'h00)
         return 3;
      if (adr[31:28] == 4'h0)
         return 0;
      if (adr[31:24] == 8'h92)
         return 1;
      return 2;
   endfunction

   function automatic dat_t slave_data(input int s);
      case (s)
         0: return SLV0_DAT;
         1: return SLV1_DAT;
         2: return SLV2_DAT;
         default: return SLV3_DAT;
      endcase
   endfunction

   task automatic check_vec(input string what, input slave_vec_t got, input slave_vec_t exp);
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_adr(input string what, input adr_t got, input adr_t exp);
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_dat(input string what, input dat_t got, input dat_t exp);
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_sel(input string what, input sel_t got, input sel_t exp);
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic drive_request(input int m, input adr_t adr, input logic we);
      m_adr[m] = adr;
      m_dat[m] = ~adr;
      m_sel[m] = (m == 0) ? 4'hc : 4'h3;
      m_we[m]  = we;
      m_cyc[m] = 1'b1;
      m_stb[m] = 1'b0;
   endtask

   task automatic release_request(input int m);
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
   endtask

   // Samples on falling edges; the other master must stay silent meanwhile
   task automatic wait_response(input int m, input int max_cycles, output logic ack,
                                output logic err, output logic rty, output dat_t rdat);
      logic done;
      done = 1'b0;
      ack  = 1'b0;
      err  = 1'b0;
      rty  = 1'b0;
      rdat = '0;
      for (int i = 0; i < max_cycles && !done; i++) begin
         @(negedge wb_clk);
         check_bit("other master ack", m_ack[1-m], 1'b0);
         check_bit("other master err", m_err[1-m], 1'b0);
         check_bit("other master rty", m_rty[1-m], 1'b0);
         if (m_ack[m] || m_err[m] || m_rty[m]) begin
            ack  = m_ack[m];
            err  = m_err[m];
            rty  = m_rty[m];
            rdat = (m == 0) ? wbm0_dat : wbm1_dat;
            done = 1'b1;
         end
      end
      if (!done) begin
         timeout_count++;
         $display("Timeout: master %0d got no response within %0d cycles", m, max_cycles);
      end
   endtask

   task automatic run_access(input int m, input adr_t adr, input logic exp_ack,
                             input logic exp_err, input logic exp_rty);
      slave_vec_t exp_sel;
      logic       ack;
      logic       err;
      logic       rty;
      dat_t       rdat;
      exp_sel = slave_vec_t'(1) << expected_slave(adr);
      @(negedge wb_clk);
      // Address bit 2 picks a write
      drive_request(m, adr, adr[2]);
      // Address goes out one cycle ahead of the strobe
      @(negedge wb_clk);
      m_stb[m] = 1'b1;
      @(negedge wb_clk);
      check_vec("wbs_cyc_o", wbs_cyc_o, exp_sel);
      check_vec("wbs_stb_o", wbs_stb_o, exp_sel);
      check_adr("wbs_adr_o", wbs_adr_o, adr);
      check_dat("wbs_dat_o", wbs_dat_o, m_dat[m]);
      check_sel("wbs_sel_o", wbs_sel_o, m_sel[m]);
      check_bit("wbs_we_o", wbs_we_o, m_we[m]);
      wait_response(m, 20, ack, err, rty, rdat);
      release_request(m);
      check_bit("ack", ack, exp_ack);
      check_bit("err", err, exp_err);
      check_bit("rty", rty, exp_rty);
      if (exp_ack)
         check_dat("read data", rdat, slave_data(expected_slave(adr)));
   endtask

   task automatic test_decode();
      adr_t r;
      adr_t adr;
      run_access(0, 32'h0000_1234, 1'b1, 1'b0, 1'b0);
      run_access(1, 32'h00FF_FFFC, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h0100_0000, 1'b1, 1'b0, 1'b0);
      run_access(1, 32'h0FFF_FFF0, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h9200_0000, 1'b1, 1'b0, 1'b0);
      run_access(1, 32'h92FF_FFFC, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h1000_0000, 1'b1, 1'b0, 1'b0);
      run_access(1, 32'h9300_0000, 1'b1, 1'b0, 1'b0);
      for (int i = 0; i < 20; i++) begin
         r = lcg_next();
         // Steer the top bits so every region gets hits
         case (r[31:30])
            2'd0: adr = {8'h00, r[23:0]};
            2'd1: adr = {4'h0, r[27:0]};
            2'd2: adr = {8'h92, r[23:0]};
            default: adr = r;
         endcase
         run_access(i % 2, adr, 1'b1, 1'b0, 1'b0);
      end
   endtask

   task automatic test_read_path();
      slv_wait[0] = 3;
      run_access(0, 32'h0200_0010, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h9200_0020, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h4000_0030, 1'b1, 1'b0, 1'b0);
      run_access(0, 32'h0000_0040, 1'b1, 1'b0, 1'b0);
      slv_wait[0] = 0;
   endtask

   task automatic test_priority();
      logic ack;
      logic err;
      logic rty;
      dat_t rdat;
      slv_wait[1] = 2;
      @(negedge wb_clk);
      drive_request(0, 32'h0800_0040, 1'b1);
      drive_request(1, 32'h9200_0100, 1'b0);
      @(negedge wb_clk);
      m_stb = 2'b11;
      @(negedge wb_clk);
      check_vec("wbs_stb_o", wbs_stb_o, 4'b0010);
      check_adr("wbs_adr_o", wbs_adr_o, 32'h9200_0100);
      check_dat("wbs_dat_o", wbs_dat_o, m_dat[1]);
      check_sel("wbs_sel_o", wbs_sel_o, m_sel[1]);
      check_bit("wbs_we_o", wbs_we_o, m_we[1]);
      wait_response(1, 20, ack, err, rty, rdat);
      check_bit("wbm1 ack", ack, 1'b1);
      check_dat("wbm1 read data", rdat, SLV1_DAT);
      release_request(1);
      wait_response(0, 20, ack, err, rty, rdat);
      check_bit("wbm0 ack", ack, 1'b1);
      check_dat("wbm0 read data", rdat, SLV0_DAT);
      release_request(0);
      slv_wait[1] = 0;
   endtask

   task automatic test_error_retry();
      slv_mode[1] = MODE_ERR;
      run_access(1, 32'h9200_0200, 1'b0, 1'b1, 1'b0);
      slv_mode[1] = MODE_RTY;
      run_access(0, 32'h9200_0204, 1'b0, 1'b0, 1'b1);
      slv_mode[1] = MODE_ACK;
   endtask

   task automatic test_watchdog();
      logic ack;
      logic err;
      logic rty;
      dat_t rdat;
      int   pulses;
      slv_mode[2] = MODE_NONE;
      @(negedge wb_clk);
      drive_request(0, 32'h4000_0100, 1'b0);
      @(negedge wb_clk);
      m_stb[0] = 1'b1;
      wait_response(0, 200, ack, err, rty, rdat);
      check_bit("watchdog err", err, 1'b1);
      check_bit("watchdog ack", ack, 1'b0);
      pulses = err;
      // Hold the stalled request a little longer
      for (int i = 0; i < 4; i++) begin
         @(negedge wb_clk);
         check_bit("ack while stalled", m_ack[0], 1'b0);
         if (m_err[0])
            pulses++;
      end
      release_request(0);
      if (pulses != 1) begin
         err_count++;
         $display("[ERROR] %0t: watchdog gave %0d err pulses, expected 1", $time, pulses);
      end
      slv_mode[2] = MODE_ACK;
   endtask

   initial begin
      wb_rst = 1'b1;
      m_we   = '0;
      m_cyc  = '0;
      m_stb  = '0;
      for (int m = 0; m < 2; m++) begin
         m_adr[m] = '0;
         m_dat[m] = '0;
         m_sel[m] = '0;
      end
      for (int s = 0; s < 4; s++) begin
         slv_mode[s] = MODE_ACK;
         slv_wait[s] = 0;
      end
      repeat (10) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);
      check_vec("idle wbs_cyc_o", wbs_cyc_o, '0);
      check_vec("idle wbs_stb_o", wbs_stb_o, '0);
      for (int m = 0; m < 2; m++) begin
         check_bit("idle master ack", m_ack[m], 1'b0);
         check_bit("idle master err", m_err[m], 1'b0);
         check_bit("idle master rty", m_rty[m], 1'b0);
      end

      test_decode();
      test_read_path();
      test_priority();
      test_error_retry();
      test_watchdog();

      repeat (2) @(negedge wb_clk);
      $display("Summary: %0d value errors, %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
